/* all.f */
+incdir+.
periph_pkg.sv
periph_timer.sv
periph_irq_sampler.sv
periph_irq_ctrl.sv
periph_top.sv
periph_assertions.sv
tb_periph_top.sv

/* Bender.yml */
package:
  name: periph

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - periph_pkg.sv
      - periph_timer.sv
      - periph_irq_sampler.sv
      - periph_irq_ctrl.sv
      - periph_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - periph_assertions.sv
      - tb_periph_top.sv

/* tb_periph_top.sv */
/*
 * Testbench for the peripheral subsystem.
 * Applies a table of bus accesses, line changes and interrupt waits
 * and checks the responses against the register map.
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

module tb_periph_top import periph_pkg::*; ();

    localparam logic [2:0] op_write    = 3'd0;
    localparam logic [2:0] op_read     = 3'd1;
    localparam logic [2:0] op_ext      = 3'd2;
    localparam logic [2:0] op_wait_irq = 3'd3;
    localparam logic [2:0] op_poll     = 3'd4;
    localparam logic [2:0] op_quiet    = 3'd5;

    localparam int timeout_cycles = 200;

    // wdata is the line value, irq level or cycle count for non-bus ops
    typedef struct packed {
        logic [2:0] op;
        addr_t      addr;
        data_t      wdata;
        data_t      exp_rdata;
        logic       exp_err;
    } entry_t;

    logic     clk_i;
    logic     arst_n_i;
    bus_req_t bus_req;
    bus_rsp_t bus_rsp;
    ext_irq_t ext_irq;
    logic     irq;

    entry_t table_q[$];
    integer seed;
    int     pass_cnt;
    int     fail_cnt;

    periph_top i_periph_top (
        .clk_i     ( clk_i    ),
        .arst_n_i  ( arst_n_i ),
        .bus_req_i ( bus_req  ),
        .bus_rsp_o ( bus_rsp  ),
        .ext_irq_i ( ext_irq  ),
        .irq_o     ( irq      )
    );

    always #50 clk_i = ~clk_i;

    function automatic string op_name(input logic [2:0] op);
        case (op)
            op_write:    return "write";
            op_read:     return "read";
            op_ext:      return "ext";
            op_wait_irq: return "wait_irq";
            op_poll:     return "poll";
            default:     return "quiet";
        endcase
    endfunction

    task automatic add_entry(input logic [2:0] op, input addr_t addr, input data_t wdata,
                             input data_t exp_rdata, input logic exp_err);
        entry_t e;
        e = '{op: op, addr: addr, wdata: wdata, exp_rdata: exp_rdata, exp_err: exp_err};
        table_q.push_back(e);
    endtask

    // one strobe and then wait for the response
    task automatic bus_access(input logic wr, input addr_t addr, input data_t wdata,
                              output data_t rdata, output logic err, output logic done);
        int cnt;
        cnt = 0;
        @(negedge clk_i);
        bus_req = '{valid: 1'b1, write: wr, addr: addr, wdata: wdata};
        @(negedge clk_i);
        bus_req.valid = 1'b0;
        while (bus_rsp.valid !== 1'b1 && cnt < timeout_cycles) begin
            @(negedge clk_i);
            cnt++;
        end
        done  = (bus_rsp.valid === 1'b1);
        rdata = bus_rsp.rdata;
        err   = bus_rsp.error;
    endtask

    task automatic run_entry(input entry_t e, output logic ok);
        data_t rdata;
        logic  err;
        logic  done;
        int    cnt;
        ok = 1'b1;
        case (e.op)
            op_write, op_read: begin
                bus_access(e.op == op_write, e.addr, e.wdata, rdata, err, done);
                if (!done) begin
                    $display("timeout: no bus response for address %h", e.addr);
                    ok = 1'b0;
                end else begin
                    if (rdata !== e.exp_rdata) begin
                        $display("mismatch at %0t: addr %h rdata %h, expected %h",
                                 $time, e.addr, rdata, e.exp_rdata);
                        ok = 1'b0;
                    end
                    if (err !== e.exp_err) begin
                        $display("mismatch at %0t: addr %h error %b, expected %b",
                                 $time, e.addr, err, e.exp_err);
                        ok = 1'b0;
                    end
                end
            end
            op_ext: begin
                @(negedge clk_i);
                ext_irq = e.wdata[`PERIPH_NUM_EXT-1:0];
            end
            op_wait_irq: begin
                cnt = 0;
                while (irq !== e.wdata[0] && cnt < timeout_cycles) begin
                    @(negedge clk_i);
                    cnt++;
                end
                if (irq !== e.wdata[0]) begin
                    $display("timeout: irq_o never went to %b", e.wdata[0]);
                    ok = 1'b0;
                end
            end
            op_poll: begin
                cnt  = 0;
                done = 1'b0;
                rdata = '0;
                while (rdata !== e.exp_rdata && cnt < timeout_cycles / 2) begin
                    bus_access(1'b0, e.addr, '0, rdata, err, done);
                    cnt++;
                end
                if (rdata !== e.exp_rdata) begin
                    $display("timeout: address %h never read %h, last %h",
                             e.addr, e.exp_rdata, rdata);
                    ok = 1'b0;
                end
            end
            default: begin
                // irq_o must hold its level for the whole window
                repeat (e.wdata) begin
                    @(negedge clk_i);
                    if (irq !== e.exp_rdata[0]) begin
                        $display("mismatch at %0t: irq_o %b, expected %b",
                                 $time, irq, e.exp_rdata[0]);
                        ok = 1'b0;
                    end
                end
            end
        endcase
    endtask

    initial begin
        data_t cmp0;
        data_t cmp1;
        logic  ok;
        int    assert_fails;
        clk_i    = 1'b0;
        arst_n_i = 1'b0;
        bus_req  = '0;
        ext_irq  = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        seed     = 32'h79fb;
        cmp0     = $random(seed);
        // large enough that channel 1 never matches while briefly enabled
        cmp1     = $random(seed) | 32'h0001_0000;

        // ------------------------------------------------------------
        // stimulus table
        // ------------------------------------------------------------
        // timer registers
        add_entry(op_write, 8'h04, cmp0, '0, 1'b0);
        add_entry(op_write, 8'h14, cmp1, '0, 1'b0);
        add_entry(op_read,  8'h04, '0, cmp0, 1'b0);
        add_entry(op_read,  8'h14, '0, cmp1, 1'b0);
        add_entry(op_write, 8'h10, 32'd1, '0, 1'b0);
        add_entry(op_read,  8'h10, '0, 32'd1, 1'b0);
        add_entry(op_write, 8'h10, 32'd0, '0, 1'b0);
        add_entry(op_read,  8'h10, '0, 32'd0, 1'b0);
        // unmapped and misaligned
        add_entry(op_read,  8'h30, '0, `PERIPH_ERR_DATA, 1'b1);
        add_entry(op_write, 8'h30, 32'h1234, `PERIPH_ERR_DATA, 1'b1);
        add_entry(op_read,  8'hfc, '0, `PERIPH_ERR_DATA, 1'b1);
        add_entry(op_write, 8'hfc, 32'h5678, `PERIPH_ERR_DATA, 1'b1);
        add_entry(op_read,  8'h05, '0, `PERIPH_ERR_DATA, 1'b1);
        // timer 0 interrupt
        add_entry(op_write,    8'h24, 32'h01, '0, 1'b0);
        add_entry(op_write,    8'h04, 32'd20, '0, 1'b0);
        add_entry(op_write,    8'h00, 32'd1, '0, 1'b0);
        add_entry(op_wait_irq, 8'h00, 32'd1, '0, 1'b0);
        add_entry(op_write,    8'h00, 32'd0, '0, 1'b0);
        add_entry(op_read,     8'h20, '0, 32'h01, 1'b0);
        add_entry(op_read,     8'h28, '0, 32'd1, 1'b0);
        add_entry(op_read,     8'h28, '0, 32'd0, 1'b0);
        add_entry(op_wait_irq, 8'h00, 32'd0, '0, 1'b0);
        // external lines 1 and 3
        add_entry(op_write,    8'h24, 32'h3c, '0, 1'b0);
        add_entry(op_ext,      8'h00, 32'ha, '0, 1'b0);
        add_entry(op_poll,     8'h20, '0, 32'h28, 1'b0);
        add_entry(op_read,     8'h28, '0, 32'd4, 1'b0);
        add_entry(op_read,     8'h28, '0, 32'd6, 1'b0);
        add_entry(op_read,     8'h28, '0, 32'd0, 1'b0);
        add_entry(op_wait_irq, 8'h00, 32'd0, '0, 1'b0);
        add_entry(op_quiet,    8'h00, 32'd20, 32'd0, 1'b0);
        add_entry(op_read,     8'h20, '0, 32'h00, 1'b0);
        add_entry(op_ext,      8'h00, 32'h0, '0, 1'b0);
        // masking with line 0
        add_entry(op_write,    8'h24, 32'h00, '0, 1'b0);
        add_entry(op_ext,      8'h00, 32'h1, '0, 1'b0);
        add_entry(op_poll,     8'h20, '0, 32'h04, 1'b0);
        add_entry(op_quiet,    8'h00, 32'd20, 32'd0, 1'b0);
        add_entry(op_write,    8'h24, 32'h04, '0, 1'b0);
        add_entry(op_wait_irq, 8'h00, 32'd1, '0, 1'b0);
        add_entry(op_read,     8'h28, '0, 32'd3, 1'b0);
        add_entry(op_wait_irq, 8'h00, 32'd0, '0, 1'b0);

        repeat (5) @(negedge clk_i);
        arst_n_i = 1'b1;

        foreach (table_q[i]) begin
            run_entry(table_q[i], ok);
            if (ok) begin
                pass_cnt++;
            end else begin
                fail_cnt++;
            end
            $display("entry %0d %s addr %h: %s", i, op_name(table_q[i].op),
                     table_q[i].addr, ok ? "ok" : "failed");
        end

        assert_fails = i_periph_top.i_periph_assertions.err_cnt;
        $display("entries %0d, passed %0d, failed %0d, assertion failures %0d",
                 table_q.size(), pass_cnt, fail_cnt, assert_fails);
        if (fail_cnt == 0 && assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* periph_assertions.sv */
/*
 * Bus and reset assertions for the peripheral subsystem top.
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

module periph_assertions import periph_pkg::*; (
    input logic     clk_i,
    input logic     arst_n_i,
    input bus_req_t bus_req_i,
    input bus_rsp_t bus_rsp_i,
    input logic     irq_i
);

    // count of failed assertions
    int err_cnt = 0;

    // response exactly one cycle after each strobe
    rsp_follows_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        bus_req_i.valid |=> bus_rsp_i.valid)
        else begin
            $error("response valid missing one cycle after request");
            err_cnt++;
        end

    no_rsp_without_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !bus_req_i.valid |=> !bus_rsp_i.valid)
        else begin
            $error("response valid without a request");
            err_cnt++;
        end

    irq_low_in_reset: assert property (@(posedge clk_i)
        !arst_n_i |-> !irq_i)
        else begin
            $error("irq_o high during reset");
            err_cnt++;
        end

    err_carries_word: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (bus_rsp_i.valid && bus_rsp_i.error) |-> bus_rsp_i.rdata == `PERIPH_ERR_DATA)
        else begin
            $error("error response without the error word");
            err_cnt++;
        end

endmodule

bind periph_top periph_assertions i_periph_assertions (
    .clk_i     ( clk_i     ),
    .arst_n_i  ( arst_n_i  ),
    .bus_req_i ( bus_req_i ),
    .bus_rsp_i ( bus_rsp_o ),
    .irq_i     ( irq_o     )
);

`default_nettype wire

/* periph_top.sv */
/*
 * Peripheral subsystem top.
 * Decodes the register bus onto the timer and the interrupt
 * controller and answers unmapped accesses with an error.
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

module periph_top import periph_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  bus_req_t bus_req_i,
    output bus_rsp_t bus_rsp_o,
    input  ext_irq_t ext_irq_i,
    output logic     irq_o
);

    // window limits, 16 bytes per timer channel
    localparam addr_t timer_lo = addr_t'(`PERIPH_TIMER_BASE);
    localparam addr_t timer_hi = addr_t'(`PERIPH_TIMER_BASE + 16 * `PERIPH_NUM_TIMERS);
    localparam addr_t irqc_lo  = addr_t'(`PERIPH_IRQC_BASE);
    localparam addr_t irqc_hi  = addr_t'(`PERIPH_IRQC_BASE + 16);

    logic       aligned;
    logic       hit_timer;
    logic       hit_irqc;
    bus_req_t   timer_req;
    bus_req_t   irqc_req;
    data_t      timer_rdata;
    data_t      irqc_rdata;
    timer_irq_t timer_irq;
    ext_irq_t   ext_edge;

    logic valid_q;
    logic sel_timer_q;
    logic sel_irqc_q;
    logic err_q;

    // ------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------
    assign aligned   = (bus_req_i.addr[1:0] == 2'b00);
    assign hit_timer = aligned && bus_req_i.addr >= timer_lo && bus_req_i.addr < timer_hi;
    assign hit_irqc  = aligned && bus_req_i.addr >= irqc_lo && bus_req_i.addr < irqc_hi;

    always_comb begin
        timer_req       = bus_req_i;
        irqc_req        = bus_req_i;
        timer_req.valid = bus_req_i.valid & hit_timer;
        irqc_req.valid  = bus_req_i.valid & hit_irqc;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q     <= 1'b0;
            sel_timer_q <= 1'b0;
            sel_irqc_q  <= 1'b0;
            err_q       <= 1'b0;
        end else begin
            valid_q     <= bus_req_i.valid;
            sel_timer_q <= bus_req_i.valid & hit_timer;
            sel_irqc_q  <= bus_req_i.valid & hit_irqc;
            err_q       <= bus_req_i.valid & ~hit_timer & ~hit_irqc;
        end
    end

    // ------------------------------------------------------------
    // response, error word on reads and writes alike
    // ------------------------------------------------------------
    always_comb begin
        bus_rsp_o.valid = valid_q;
        bus_rsp_o.error = err_q;
        if (err_q) begin
            bus_rsp_o.rdata = `PERIPH_ERR_DATA;
        end else if (sel_timer_q) begin
            bus_rsp_o.rdata = timer_rdata;
        end else if (sel_irqc_q) begin
            bus_rsp_o.rdata = irqc_rdata;
        end else begin
            bus_rsp_o.rdata = '0;
        end
    end

    periph_timer i_timer (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .req_i       ( timer_req   ),
        .rdata_o     ( timer_rdata ),
        .timer_irq_o ( timer_irq   )
    );

    periph_irq_sampler i_sampler (
        .clk_i     ( clk_i     ),
        .arst_n_i  ( arst_n_i  ),
        .ext_irq_i ( ext_irq_i ),
        .edge_o    ( ext_edge  )
    );

    periph_irq_ctrl i_irq_ctrl (
        .clk_i       ( clk_i      ),
        .arst_n_i    ( arst_n_i   ),
        .req_i       ( irqc_req   ),
        .rdata_o     ( irqc_rdata ),
        .timer_irq_i ( timer_irq  ),
        .ext_edge_i  ( ext_edge   ),
        .irq_o       ( irq_o      )
    );

endmodule

`default_nettype wire

/* periph_irq_ctrl.sv */
/*
 * Interrupt controller.
 * Collects timer and external pulses into pending bits, masks them
 * with an enable register and serves claims of the lowest active id.
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

module periph_irq_ctrl import periph_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  bus_req_t   req_i,
    output data_t      rdata_o,
    input  timer_irq_t timer_irq_i,
    input  ext_irq_t   ext_edge_i,
    output logic       irq_o
);

    addr_t      rel_addr;
    logic [3:0] reg_off;
    logic       wr_en;
    logic       rd_en;
    logic       claim_rd;
    src_vec_t   src_pulse;
    src_vec_t   active;
    src_vec_t   claim_clr;
    irq_id_t    claim_id;
    data_t      rd_word;
    data_t      rdata_q;

    src_vec_t pend_q;
    src_vec_t en_q;
    logic     irq_q;

    assign rel_addr = req_i.addr - addr_t'(`PERIPH_IRQC_BASE);
    assign reg_off  = rel_addr[3:0];
    assign wr_en    = req_i.valid & req_i.write;
    assign rd_en    = req_i.valid & ~req_i.write;
    assign claim_rd = rd_en & (reg_off == `PERIPH_REG_CLAIM);

    // ids 1..2 are timers, 3..6 external lines
    assign src_pulse = {ext_edge_i, timer_irq_i};
    assign active    = pend_q & en_q;

    // ------------------------------------------------------------
    // lowest active source
    // ------------------------------------------------------------
    always_comb begin
        claim_id  = '0;
        claim_clr = '0;
        // walk downwards so the lowest bit is taken last
        for (int i = $bits(src_vec_t) - 1; i >= 0; i--) begin
            if (active[i]) begin
                claim_id  = irq_id_t'(i + 1);
                claim_clr = src_vec_t'(1) << i;
            end
        end
    end

    // ------------------------------------------------------------
    // pending, enable and interrupt output
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_q <= '0;
            en_q   <= '0;
            irq_q  <= 1'b0;
        end else begin
            // a fresh pulse on the claimed source keeps it pending
            pend_q <= (pend_q & ~(claim_rd ? claim_clr : '0)) | src_pulse;
            if (wr_en && reg_off == `PERIPH_REG_EN) begin
                en_q <= req_i.wdata[$bits(src_vec_t)-1:0];
            end
            irq_q <= |active;
        end
    end

    always_comb begin
        case (reg_off)
            `PERIPH_REG_PEND:  rd_word = data_t'(pend_q);
            `PERIPH_REG_EN:    rd_word = data_t'(en_q);
            `PERIPH_REG_CLAIM: rd_word = data_t'(claim_id);
            default:           rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        rdata_q <= rd_en ? rd_word : '0;
    end

    assign rdata_o = rdata_q;
    assign irq_o   = irq_q;

endmodule

`default_nettype wire

/* periph_irq_sampler.sv */
/*
 * External interrupt sampler.
 * Synchronizes the external lines and turns each rising edge into
 * a single-cycle pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module periph_irq_sampler import periph_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  ext_irq_t ext_irq_i,
    output ext_irq_t edge_o
);

    // two-flop synchronizer
    ext_irq_t sync1_q;
    ext_irq_t sync2_q;

    // previous synchronized level
    ext_irq_t dly_q;

    ext_irq_t edge_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            dly_q   <= '0;
            edge_q  <= '0;
        end else begin
            sync1_q <= ext_irq_i;
            sync2_q <= sync1_q;
            dly_q   <= sync2_q;
            // rising edge only, a held line fires once
            edge_q  <= sync2_q & ~dly_q;
        end
    end

    assign edge_o = edge_q;

endmodule

`default_nettype wire

/* periph_timer.sv */
/*
 * Compare timer with two channels.
 * Each channel counts up while enabled, pulses its interrupt on a
 * compare match and wraps to zero.
 */
`timescale 1ns/1ps
`default_nettype none

`include "periph_settings.svh"

module periph_timer import periph_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  bus_req_t   req_i,
    output data_t      rdata_o,
    output timer_irq_t timer_irq_o
);

    addr_t                     rel_addr;
    logic [`PERIPH_ADDR_W-5:0] ch_sel;
    logic [3:0]                reg_off;
    logic                      wr_en;
    logic                      rd_en;
    data_t                     rd_word;
    data_t                     rdata_q;

    timer_irq_t en_q;
    timer_irq_t irq_q;
    data_t      cmp_q [`PERIPH_NUM_TIMERS];
    data_t      cnt_q [`PERIPH_NUM_TIMERS];

    // channel in the upper nibble, register offset in the lower one
    assign rel_addr = req_i.addr - addr_t'(`PERIPH_TIMER_BASE);
    assign ch_sel   = rel_addr[`PERIPH_ADDR_W-1:4];
    assign reg_off  = rel_addr[3:0];
    assign wr_en    = req_i.valid & req_i.write;
    assign rd_en    = req_i.valid & ~req_i.write;

    // ------------------------------------------------------------
    // counters and registers
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            en_q  <= '0;
            irq_q <= '0;
            for (int k = 0; k < `PERIPH_NUM_TIMERS; k++) begin
                cmp_q[k] <= '0;
                cnt_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < `PERIPH_NUM_TIMERS; k++) begin
                irq_q[k] <= 1'b0;
                if (en_q[k]) begin
                    if (cnt_q[k] == cmp_q[k]) begin
                        cnt_q[k] <= '0;
                        irq_q[k] <= 1'b1;
                    end else begin
                        cnt_q[k] <= cnt_q[k] + 1'b1;
                    end
                end
                // a bus write to the count wins over counting
                if (wr_en && ch_sel == k) begin
                    case (reg_off)
                        `PERIPH_REG_CTRL: en_q[k]  <= req_i.wdata[0];
                        `PERIPH_REG_CMP:  cmp_q[k] <= req_i.wdata;
                        `PERIPH_REG_CNT:  cnt_q[k] <= req_i.wdata;
                        default: ;
                    endcase
                end
            end
        end
    end

    // ------------------------------------------------------------
    // read back
    // ------------------------------------------------------------
    always_comb begin
        rd_word = '0;
        for (int k = 0; k < `PERIPH_NUM_TIMERS; k++) begin
            if (ch_sel == k) begin
                case (reg_off)
                    `PERIPH_REG_CTRL: rd_word = data_t'(en_q[k]);
                    `PERIPH_REG_CMP:  rd_word = cmp_q[k];
                    `PERIPH_REG_CNT:  rd_word = cnt_q[k];
                    default:          rd_word = '0;
                endcase
            end
        end
    end

    // zero unless a read was strobed
    always_ff @(posedge clk_i) begin
        rdata_q <= rd_en ? rd_word : '0;
    end

    assign rdata_o     = rdata_q;
    assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

/* periph_pkg.sv */
/*
 * Peripheral subsystem package.
 * Vector types and the register bus request and response.
 */
`default_nettype none

`include "periph_settings.svh"

package periph_pkg;

    // ------------------------------------------------------------
    // plain vectors
    // ------------------------------------------------------------
    typedef logic [`PERIPH_ADDR_W-1:0] addr_t;
    typedef logic [`PERIPH_DATA_W-1:0] data_t;

    // source id, 0 means no source
    typedef logic [$clog2(`PERIPH_NUM_TIMERS+`PERIPH_NUM_EXT+1)-1:0] irq_id_t;

    // one bit per source, timers in the low bits
    typedef logic [`PERIPH_NUM_TIMERS+`PERIPH_NUM_EXT-1:0] src_vec_t;

    typedef logic [`PERIPH_NUM_TIMERS-1:0] timer_irq_t;
    typedef logic [`PERIPH_NUM_EXT-1:0]    ext_irq_t;

    // ------------------------------------------------------------
    // register bus
    // ------------------------------------------------------------
    // one-cycle request strobe, no back-pressure
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        data_t wdata;
    } bus_req_t;

    // response one cycle after the request
    typedef struct packed {
        logic  valid;
        logic  error;
        data_t rdata;
    } bus_rsp_t;

endpackage

`default_nettype wire

/* periph_settings.svh */
/*
 * Peripheral subsystem settings.
 * Bus widths, source counts, the register map and the error word.
 */
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// bus widths
`define PERIPH_ADDR_W       8
`define PERIPH_DATA_W       32

// interrupt sources
`define PERIPH_NUM_TIMERS   2
`define PERIPH_NUM_EXT      4

// address map, timer channel k sits at base + 0x10 * k
`define PERIPH_TIMER_BASE   8'h00
`define PERIPH_IRQC_BASE    8'h20

// timer channel registers
`define PERIPH_REG_CTRL     4'h0
`define PERIPH_REG_CMP      4'h4
`define PERIPH_REG_CNT      4'h8

// interrupt controller registers
`define PERIPH_REG_PEND     4'h0
`define PERIPH_REG_EN       4'h4
`define PERIPH_REG_CLAIM    4'h8

// read data of an error response
`define PERIPH_ERR_DATA     32'hdeadbeef

`endif
